/* common/cart_pkg.sv */
// ********************
// Cartridge bus, result and config types, size code helpers
// ********************
package cart_pkg;

	// One CPU cartridge access
	typedef struct packed {
		logic [14:0] addr;
		logic        a15;
		logic        wr;
		logic [7:0]  di;
		logic        ce;     // CPU clock enable strobe
	} cart_bus_t;

	typedef enum logic [7:0] {
		KIND_ROM_ONLY = 8'h00,
		KIND_MBC1     = 8'h01,
		KIND_ROCKET   = 8'h97    // Internal code, not a header value
	} cart_kind_e;

	// Result lines shared by every source
	typedef struct packed {
		logic [22:0] mbc_addr;
		logic [7:0]  rom_do;
		logic [7:0]  cram_do;
		logic [16:0] cram_addr;
		logic        ram_enabled;
		logic        has_battery;
	} map_out_t;

	typedef struct packed {
		logic [4:0] rom_mask;    // 16 KB banks
		logic [1:0] ram_mask;    // 8 KB banks
	} cart_masks_t;

	// ROM size code to bank mask, 2^(code+1)-1 clipped to 5 bits
	function automatic logic [4:0] rom_mask_of(input logic [7:0] code);
		case (code)
			8'd0:    return 5'h01;
			8'd1:    return 5'h03;
			8'd2:    return 5'h07;
			8'd3:    return 5'h0F;
			default: return 5'h1F;
		endcase
	endfunction

	// Only the multi-bank RAM sizes need a mask
	function automatic logic [1:0] ram_mask_of(input logic [7:0] code);
		return (code >= 8'd3) ? 2'b11 : 2'b00;
	endfunction

	// Zero the address bits above the ROM bus width
	function automatic logic [22:0] clip_addr(input logic [22:0] addr, input int unsigned w);
		return addr & ~(23'h7F_FFFF << w);
	endfunction

endpackage

/* common/mapper_state_pkg.sv */
// ********************
// Mapper savestate structs and the shared savestate word
// ********************
package mapper_state_pkg;

	// Field order keeps bank in bits 3:0 and the count in 12:7
	typedef struct packed {
		logic [2:0] pad;
		logic [5:0] a15_cnt;      // a15 rising edges during boot
		logic       prev_a15;
		logic       header_end;
		logic       outer;        // Multigame outer bank
		logic [3:0] bank;
	} rocket_ss_t;

	typedef struct packed {
		logic [6:0] pad;
		logic       ram_en;
		logic       mode;         // 1 = upper bits also bank RAM
		logic [1:0] upper_bank;
		logic [4:0] low_bank;
	} mbc1_ss_t;

	// One 16-bit word, read by whichever mapper is enabled
	typedef union packed {
		rocket_ss_t rocket;
		mbc1_ss_t   mbc1;
	} ss_word_u;

endpackage

/* hw/cart_config.sv */
// ********************
// Cartridge kind and size masks, mapper enables, ROM-only mapping
// ********************
`timescale 1ns/1ps

module cart_config #(
	parameter int mbc_addr_w = 23
) (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             cfg_load,
	input  cart_pkg::cart_kind_e             cfg_kind,
	input  logic [7:0]                       cfg_rom_size,
	input  logic [7:0]                       cfg_ram_size,
	input  cart_pkg::cart_bus_t              bus,
	input  logic [7:0]                       rom_di,
	output logic                             rocket_en,
	output logic                             mbc1_en,
	output cart_pkg::cart_masks_t            masks,
	inout  wire cart_pkg::map_out_t          result,
	inout  wire mapper_state_pkg::ss_word_u  savestate_back
);

	cart_pkg::cart_kind_e kind_q;
	cart_pkg::map_out_t   map_q;
	logic                 rom_only;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			kind_q         <= cart_pkg::KIND_ROM_ONLY;
			masks.rom_mask <= cart_pkg::rom_mask_of(8'd0);   // 32 KB, two banks
			masks.ram_mask <= 2'b00;
		end else if (cfg_load) begin
			kind_q         <= cfg_kind;
			masks.rom_mask <= cart_pkg::rom_mask_of(cfg_rom_size);
			masks.ram_mask <= cart_pkg::ram_mask_of(cfg_ram_size);
		end
	end

	// Unknown kinds fall back to ROM-only, so one source always drives
	assign rocket_en = (kind_q == cart_pkg::KIND_ROCKET);
	assign mbc1_en   = (kind_q == cart_pkg::KIND_MBC1);
	assign rom_only  = ~rocket_en & ~mbc1_en;

	always_comb begin
		map_q.mbc_addr    = cart_pkg::clip_addr({7'd0, bus.a15, bus.addr}, mbc_addr_w);
		map_q.rom_do      = rom_di;
		map_q.cram_do     = 8'hFF;
		map_q.cram_addr   = {4'b0000, bus.addr[12:0]};
		map_q.ram_enabled = 1'b0;
		map_q.has_battery = 1'b0;
	end

	assign result         = rom_only ? map_q : 'z;
	assign savestate_back = rom_only ? '0 : 'z;      // Nothing to save

endmodule

/* hw/cart_top.sv */
// ********************
// Cartridge mapper subsystem top
// ********************
`timescale 1ns/1ps

module cart_top #(
	parameter int mbc_addr_w = 23
) (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  cart_pkg::cart_bus_t         bus,
	input  logic [7:0]                  rom_di,
	input  logic [7:0]                  cram_di,
	input  logic                        cfg_load,
	input  cart_pkg::cart_kind_e        cfg_kind,
	input  logic [7:0]                  cfg_rom_size,
	input  logic [7:0]                  cfg_ram_size,
	input  logic                        savestate_load,
	input  mapper_state_pkg::ss_word_u  savestate_data,
	output cart_pkg::map_out_t          result,
	output mapper_state_pkg::ss_word_u  savestate_back
);

	logic                        rocket_en;
	logic                        mbc1_en;
	cart_pkg::cart_masks_t       masks;
	wire cart_pkg::map_out_t     map_bus;   // Shared tri-state result
	wire mapper_state_pkg::ss_word_u ss_bus;

	cart_config #(
		.mbc_addr_w     (mbc_addr_w)
	) u_cart_config (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.cfg_load       (cfg_load),
		.cfg_kind       (cfg_kind),
		.cfg_rom_size   (cfg_rom_size),
		.cfg_ram_size   (cfg_ram_size),
		.bus            (bus),
		.rom_di         (rom_di),
		.rocket_en      (rocket_en),
		.mbc1_en        (mbc1_en),
		.masks          (masks),
		.result         (map_bus),
		.savestate_back (ss_bus)
	);

	rocket #(
		.mbc_addr_w     (mbc_addr_w)
	) u_rocket (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.enable         (rocket_en),
		.bus            (bus),
		.masks          (masks),
		.rom_di         (rom_di),
		.savestate_load (savestate_load),
		.savestate_data (savestate_data),
		.result         (map_bus),
		.savestate_back (ss_bus)
	);

	mbc1 #(
		.mbc_addr_w     (mbc_addr_w)
	) u_mbc1 (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.enable         (mbc1_en),
		.bus            (bus),
		.masks          (masks),
		.rom_di         (rom_di),
		.cram_di        (cram_di),
		.savestate_load (savestate_load),
		.savestate_data (savestate_data),
		.result         (map_bus),
		.savestate_back (ss_bus)
	);

	assign result         = map_bus;
	assign savestate_back = ss_bus;

endmodule

/* hw/mappers/mbc1.sv */
// ********************
// MBC1 mapper: 5+2 bit ROM bank, mode bit, RAM enable
// ********************
`timescale 1ns/1ps

module mbc1 #(
	parameter int mbc_addr_w = 23
) (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             enable,
	input  cart_pkg::cart_bus_t              bus,
	input  cart_pkg::cart_masks_t            masks,
	input  logic [7:0]                       rom_di,
	input  logic [7:0]                       cram_di,
	input  logic                             savestate_load,
	input  mapper_state_pkg::ss_word_u       savestate_data,
	inout  wire cart_pkg::map_out_t          result,
	inout  wire mapper_state_pkg::ss_word_u  savestate_back
);

	localparam mapper_state_pkg::mbc1_ss_t mbc1_idle = '{
		pad:        7'd0,
		ram_en:     1'b0,
		mode:       1'b0,
		upper_bank: 2'd0,
		low_bank:   5'd1
	};

	mapper_state_pkg::mbc1_ss_t st;
	mapper_state_pkg::ss_word_u ss_q;
	cart_pkg::map_out_t         map_q;
	logic                       reg_wr;
	logic [6:0]                 rom_mask_x;
	logic [6:0]                 rom_bank_raw;
	logic [6:0]                 rom_bank;
	logic [1:0]                 ram_bank;

	assign reg_wr = bus.wr & ~bus.a15;     // $0000-$7FFF

	always_ff @(posedge clk_sys) begin
		if (!rst_n || !enable) begin
			st <= mbc1_idle;
		end else if (savestate_load) begin
			st     <= savestate_data.mbc1;
			st.pad <= '0;
		end else if (bus.ce && reg_wr) begin
			case (bus.addr[14:13])
				2'b00: st.ram_en <= (bus.di[3:0] == 4'hA);
				2'b01: st.low_bank <= (bus.di[4:0] == 5'd0) ? 5'd1 : bus.di[4:0];
				2'b10: st.upper_bank <= bus.di[1:0];
				2'b11: st.mode <= bus.di[0];
				default: st <= st;
			endcase
		end
	end

	always_comb begin
		// Full 5-bit mask means a large ROM, so the upper bits count too
		rom_mask_x = (&masks.rom_mask) ? 7'h7F : {2'b00, masks.rom_mask};

		if (bus.addr[14]) begin
			rom_bank_raw = {st.upper_bank, st.low_bank};
		end else begin
			rom_bank_raw = st.mode ? {st.upper_bank, 5'd0} : 7'd0;   // Mode 1 banks $0000 too
		end
		rom_bank = rom_bank_raw & rom_mask_x;

		ram_bank = st.mode ? (st.upper_bank & masks.ram_mask) : 2'b00;

		map_q.mbc_addr    = cart_pkg::clip_addr({2'b00, rom_bank, bus.addr[13:0]}, mbc_addr_w);
		map_q.rom_do      = rom_di;
		map_q.cram_do     = st.ram_en ? cram_di : 8'hFF;   // Open bus while locked
		map_q.cram_addr   = {2'b00, ram_bank, bus.addr[12:0]};
		map_q.ram_enabled = st.ram_en;
		map_q.has_battery = 1'b0;

		ss_q.mbc1 = st;
	end

	assign result         = enable ? map_q : 'z;
	assign savestate_back = enable ? ss_q : 'z;

endmodule

/* hw/mappers/rocket.sv */
// ********************
// Rocket Games mapper: bank registers, outer bank, header descrambling
// ********************
`timescale 1ns/1ps

module rocket #(
	parameter int mbc_addr_w = 23
) (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             enable,
	input  cart_pkg::cart_bus_t              bus,
	input  cart_pkg::cart_masks_t            masks,
	input  logic [7:0]                       rom_di,
	input  logic                             savestate_load,
	input  mapper_state_pkg::ss_word_u       savestate_data,
	inout  wire cart_pkg::map_out_t          result,
	inout  wire mapper_state_pkg::ss_word_u  savestate_back
);

	// Boot header key, applied until the logo has been read twice
	localparam logic [7:0] hdr_xor [0:51] = '{
		8'h00, 8'h00, 8'h00, 8'h00, 8'hDF, 8'hCE, 8'h97, 8'h78,
		8'hCD, 8'h2F, 8'hF0, 8'h0B, 8'h0B, 8'hEA, 8'h78, 8'h83,
		8'h08, 8'h1D, 8'h9A, 8'h45, 8'h11, 8'h2B, 8'hE1, 8'h11,
		8'hF8, 8'h88, 8'hF8, 8'h8E, 8'hFE, 8'h88, 8'h2A, 8'hC4,
		8'hFF, 8'hFC, 8'hD9, 8'h87, 8'h22, 8'hAB, 8'h67, 8'h7D,
		8'h77, 8'h2C, 8'hA8, 8'hEE, 8'hFF, 8'h9B, 8'h99, 8'h91,
		8'hAA, 8'h9B, 8'h33, 8'h3E
	};

	localparam mapper_state_pkg::rocket_ss_t rocket_idle = '{
		pad:        3'd0,
		a15_cnt:    6'd0,
		prev_a15:   1'b1,
		header_end: 1'b0,
		outer:      1'b0,
		bank:       4'd1
	};

	mapper_state_pkg::rocket_ss_t st;     // All mapper state
	mapper_state_pkg::ss_word_u   ss_q;
	cart_pkg::map_out_t           map_q;
	logic                         bank_wr;
	logic                         a15_rise;
	logic [4:0]                   rom_bank;

	function automatic logic [7:0] hdr_key(input logic [5:0] idx);
		if (idx < 6'd52) begin
			return hdr_xor[idx];
		end
		return 8'h00;
	endfunction

	assign bank_wr  = bus.wr & ~bus.a15 & (bus.addr[14:13] == 2'b01);   // $2000-$3FFF
	assign a15_rise = ~st.prev_a15 & bus.a15;

	always_ff @(posedge clk_sys) begin
		if (!rst_n || !enable) begin
			st <= rocket_idle;
		end else if (savestate_load) begin
			st     <= savestate_data.rocket;
			st.pad <= '0;
		end else if (bus.ce) begin
			if (bank_wr) begin
				if (&bus.addr[7:6]) begin
					st.outer <= bus.di[0];     // Multigame select at $3FC0
				end else begin
					st.bank <= (bus.di[3:0] == 4'd0) ? 4'd1 : bus.di[3:0];
				end
			end

			// Boot ROM reads the 48-byte logo twice, a15 drops for each header read
			st.prev_a15 <= bus.a15;
			if (a15_rise && !st.header_end) begin
				st.a15_cnt <= st.a15_cnt + 6'd1;
				if (st.a15_cnt == 6'd47) begin
					st.header_end <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		// Low 16 KB is bank 0 of the selected game
		rom_bank = {st.outer, bus.addr[14] ? st.bank : 4'd0} & masks.rom_mask;

		map_q.mbc_addr    = cart_pkg::clip_addr({4'b0000, rom_bank, bus.addr[13:0]}, mbc_addr_w);
		map_q.rom_do      = st.header_end ? rom_di : (rom_di ^ hdr_key(bus.addr[5:0]));
		map_q.cram_do     = 8'hFF;           // No cartridge RAM
		map_q.cram_addr   = {4'b0000, bus.addr[12:0]};
		map_q.ram_enabled = 1'b0;
		map_q.has_battery = 1'b0;

		ss_q.rocket = st;
	end

	// Drive the shared lines only while selected
	assign result         = enable ? map_q : 'z;
	assign savestate_back = enable ? ss_q : 'z;

endmodule

/* verif/cart_properties.sv */
// ********************
// Assertions on the mapper enables and shared result lines
// ********************
`timescale 1ns/1ps

module cart_properties (
	input logic                        clk_sys,
	input logic                        rst_n,
	input logic                        cfg_load,
	input cart_pkg::cart_kind_e        cfg_kind,
	input logic                        rocket_en,
	input logic                        mbc1_en,
	input cart_pkg::map_out_t          result,
	input mapper_state_pkg::ss_word_u  savestate_back
);

	// At most one mapper, taking the loaded kind one cycle after each load
	enables_valid: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({rocket_en, mbc1_en}) &&
		($past(cfg_load) ?
			((rocket_en == ($past(cfg_kind) == cart_pkg::KIND_ROCKET)) &&
			 (mbc1_en == ($past(cfg_kind) == cart_pkg::KIND_MBC1))) :
			$stable({rocket_en, mbc1_en}))
	) else $error("Mapper enables are not one-hot or do not follow the loaded kind");

	// A missing or doubled driver shows up as X or Z
	lines_known: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!$isunknown(result) && !$isunknown(savestate_back)
	) else $error("Shared result lines carry X or Z");

	rocket_no_ram: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		rocket_en |-> !result.ram_enabled
	) else $error("ram_enabled set while the Rocket mapper is enabled");

endmodule

bind cart_top cart_properties u_cart_properties (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.cfg_load       (cfg_load),
	.cfg_kind       (cfg_kind),
	.rocket_en      (rocket_en),
	.mbc1_en        (mbc1_en),
	.result         (map_bus),
	.savestate_back (ss_bus)
);

/* verif/cart_tb.sv */
// ********************
// Cartridge mapper testbench: stimulus table, LFSR data, checks, timeout
// ********************
`timescale 1ns/1ps

module cart_tb;

	typedef enum logic [2:0] {OP_CFG, OP_WR, OP_RD, OP_A15, OP_SS, OP_CRAM} op_e;

	typedef struct packed {
		op_e         op;
		logic [15:0] addr;      // CPU address with a15 on top, size codes for OP_CFG
		logic [15:0] data;      // Write data, kind, a15 edge count or savestate word
		logic [22:0] exp_val;   // mbc_addr, cram_addr or savestate word
		logic        flag;      // Descrambled or RAM on
	} row_t;

	localparam int reset_cycles = 5;

	// Header key of the Rocket boot sequence
	localparam logic [7:0] key_tab [0:51] = '{
		8'h00, 8'h00, 8'h00, 8'h00, 8'hDF, 8'hCE, 8'h97, 8'h78,
		8'hCD, 8'h2F, 8'hF0, 8'h0B, 8'h0B, 8'hEA, 8'h78, 8'h83,
		8'h08, 8'h1D, 8'h9A, 8'h45, 8'h11, 8'h2B, 8'hE1, 8'h11,
		8'hF8, 8'h88, 8'hF8, 8'h8E, 8'hFE, 8'h88, 8'h2A, 8'hC4,
		8'hFF, 8'hFC, 8'hD9, 8'h87, 8'h22, 8'hAB, 8'h67, 8'h7D,
		8'h77, 8'h2C, 8'hA8, 8'hEE, 8'hFF, 8'h9B, 8'h99, 8'h91,
		8'hAA, 8'h9B, 8'h33, 8'h3E
	};

	logic                        clk_sys;
	logic                        rst_n;
	cart_pkg::cart_bus_t         bus;
	logic [7:0]                  rom_di;
	logic [7:0]                  cram_di;
	logic                        cfg_load;
	cart_pkg::cart_kind_e        cfg_kind;
	logic [7:0]                  cfg_rom_size;
	logic [7:0]                  cfg_ram_size;
	logic                        savestate_load;
	mapper_state_pkg::ss_word_u  savestate_data;
	wire cart_pkg::map_out_t     result;
	wire mapper_state_pkg::ss_word_u savestate_back;

	row_t        rows_q[$];
	logic [15:0] lfsr_q;
	int          fail_count = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;

	cart_top #(
		.mbc_addr_w     (23)
	) u_cart_top (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.bus            (bus),
		.rom_di         (rom_di),
		.cram_di        (cram_di),
		.cfg_load       (cfg_load),
		.cfg_kind       (cfg_kind),
		.cfg_rom_size   (cfg_rom_size),
		.cfg_ram_size   (cfg_ram_size),
		.savestate_load (savestate_load),
		.savestate_data (savestate_data),
		.result         (result),
		.savestate_back (savestate_back)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout: the table did not finish within %0d cycles", cycle_limit);
			$display("Some tests failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [7:0] header_key(input logic [5:0] idx);
		return (idx < 6'd52) ? key_tab[idx] : 8'h00;
	endfunction

	task automatic next_rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			b[i]   = lfsr_q[0];
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp_v);
		if (got !== exp_v) begin
			fail_count++;
			$display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp_v);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic bus_idle();
		bus = '0;                 // a15 low, no strobe
	endtask

	task automatic add_row(input op_e op, input logic [15:0] addr, input logic [15:0] data,
			input logic [22:0] exp_val, input logic flag);
		rows_q.push_back('{op: op, addr: addr, data: data, exp_val: exp_val, flag: flag});
	endtask

	task automatic build_rows();
		// ROM-only after reset
		add_row(OP_RD,   16'h0123, 16'h0000, 23'h000123, 1'b0);
		add_row(OP_RD,   16'h5ABC, 16'h0000, 23'h005ABC, 1'b0);
		add_row(OP_RD,   16'hC010, 16'h0000, 23'h00C010, 1'b0);
		// Rocket bank register, 512 KB
		add_row(OP_CFG,  16'h0400, 16'h0097, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h0104, 16'h0000, 23'h000104, 1'b1);
		add_row(OP_RD,   16'h4005, 16'h0000, 23'h004005, 1'b1);
		add_row(OP_WR,   16'h2000, 16'h0000, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h4010, 16'h0000, 23'h004010, 1'b1);
		add_row(OP_WR,   16'h2000, 16'h0003, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h7FFF, 16'h0000, 23'h00FFFF, 1'b1);
		add_row(OP_WR,   16'h2000, 16'h000F, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h4020, 16'h0000, 23'h03C020, 1'b1);
		add_row(OP_RD,   16'h1234, 16'h0000, 23'h001234, 1'b1);
		add_row(OP_WR,   16'h3FC0, 16'h0001, 23'h000000, 1'b0);   // Outer bank
		add_row(OP_RD,   16'h4008, 16'h0000, 23'h07C008, 1'b1);
		add_row(OP_RD,   16'h0008, 16'h0000, 23'h040008, 1'b1);
		add_row(OP_CFG,  16'h0100, 16'h0097, 23'h000000, 1'b0);   // 64 KB mirrors
		add_row(OP_RD,   16'h4030, 16'h0000, 23'h00C030, 1'b1);
		// Header descrambling ends at the 48th a15 edge
		add_row(OP_A15,  16'h0000, 16'd47,   23'h000000, 1'b0);
		add_row(OP_RD,   16'h0104, 16'h0000, 23'h000104, 1'b1);
		add_row(OP_A15,  16'h0000, 16'd1,    23'h000000, 1'b0);
		add_row(OP_RD,   16'h0104, 16'h0000, 23'h000104, 1'b0);
		add_row(OP_RD,   16'h4031, 16'h0000, 23'h00C031, 1'b0);
		// Rocket savestate
		add_row(OP_CFG,  16'h0400, 16'h0097, 23'h000000, 1'b0);
		add_row(OP_SS,   16'h0000, 16'h1865, 23'h001865, 1'b0);
		add_row(OP_RD,   16'h4000, 16'h0000, 23'h014000, 1'b0);
		// MBC1, 2 MB ROM and 32 KB RAM
		add_row(OP_CFG,  16'h0603, 16'h0001, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h4000, 16'h0000, 23'h004000, 1'b0);
		add_row(OP_WR,   16'h2000, 16'h0000, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h4001, 16'h0000, 23'h004001, 1'b0);
		add_row(OP_WR,   16'h2000, 16'h0013, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h4002, 16'h0000, 23'h04C002, 1'b0);
		add_row(OP_WR,   16'h4000, 16'h0002, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h4003, 16'h0000, 23'h14C003, 1'b0);
		add_row(OP_RD,   16'h0004, 16'h0000, 23'h000004, 1'b0);
		add_row(OP_CRAM, 16'hA010, 16'h0000, 23'h000010, 1'b0);
		add_row(OP_WR,   16'h6000, 16'h0001, 23'h000000, 1'b0);   // Mode 1
		add_row(OP_RD,   16'h0005, 16'h0000, 23'h100005, 1'b0);
		add_row(OP_CRAM, 16'hA020, 16'h0000, 23'h004020, 1'b0);
		add_row(OP_WR,   16'h0000, 16'h000A, 23'h000000, 1'b0);
		add_row(OP_CRAM, 16'hB234, 16'h0000, 23'h005234, 1'b1);
		// Same word through the MBC1 view
		add_row(OP_SS,   16'h0000, 16'h1865, 23'h000065, 1'b0);
		add_row(OP_RD,   16'h4000, 16'h0000, 23'h194000, 1'b0);
		add_row(OP_CRAM, 16'hA000, 16'h0000, 23'h000000, 1'b0);
		// Back to ROM-only
		add_row(OP_CFG,  16'h0000, 16'h0000, 23'h000000, 1'b0);
		add_row(OP_RD,   16'h8123, 16'h0000, 23'h008123, 1'b0);
	endtask

	// Entered and left a small delay after a rising edge
	task automatic apply_row(input row_t r);
		logic [7:0] exp_do;
		case (r.op)
			OP_CFG: begin
				cfg_kind     = cart_pkg::cart_kind_e'(r.data[7:0]);
				cfg_rom_size = r.addr[15:8];
				cfg_ram_size = r.addr[7:0];
				cfg_load     = 1'b1;
				@(posedge clk_sys);
				#1 cfg_load = 1'b0;
			end
			OP_WR: begin
				bus.addr = r.addr[14:0];
				bus.a15  = r.addr[15];
				bus.di   = r.data[7:0];
				bus.wr   = 1'b1;
				bus.ce   = 1'b1;
				@(posedge clk_sys);
				#1 bus_idle();
			end
			OP_A15: begin
				repeat (r.data) begin
					bus.ce  = 1'b1;
					bus.a15 = 1'b0;
					@(posedge clk_sys);
					#1 bus.a15 = 1'b1;
					@(posedge clk_sys);
					#1;
				end
				bus_idle();
			end
			OP_SS: begin
				savestate_data = r.data;
				savestate_load = 1'b1;
				@(posedge clk_sys);
				#1 savestate_load = 1'b0;
				@(negedge clk_sys);
				check_value("savestate_back", savestate_back, r.exp_val[15:0]);
				@(posedge clk_sys);
				#1;
			end
			OP_RD: begin
				bus.addr = r.addr[14:0];
				bus.a15  = r.addr[15];
				next_rand_byte(rom_di);
				@(negedge clk_sys);
				exp_do = r.flag ? (rom_di ^ header_key(r.addr[5:0])) : rom_di;
				check_value("mbc_addr", result.mbc_addr, r.exp_val);
				check_value("rom_do", result.rom_do, exp_do);
				check_value("has_battery", result.has_battery, 1'b0);
				@(posedge clk_sys);
				#1 bus_idle();
			end
			default: begin
				bus.addr = r.addr[14:0];
				bus.a15  = r.addr[15];
				next_rand_byte(cram_di);
				@(negedge clk_sys);
				check_value("cram_addr", result.cram_addr, r.exp_val[16:0]);
				check_value("cram_do", result.cram_do, r.flag ? cram_di : 8'hFF);
				check_value("ram_enabled", result.ram_enabled, r.flag);
				@(posedge clk_sys);
				#1 bus_idle();
			end
		endcase
	endtask

	initial begin
		int a15_edges;
		rst_n          = 1'b0;
		bus_idle();
		rom_di         = 8'h00;
		cram_di        = 8'h00;
		cfg_load       = 1'b0;
		cfg_kind       = cart_pkg::KIND_ROM_ONLY;
		cfg_rom_size   = 8'h00;
		cfg_ram_size   = 8'h00;
		savestate_load = 1'b0;
		savestate_data = '0;
		lfsr_q         = 16'd77;

		build_rows();
		a15_edges = 0;
		foreach (rows_q[i]) begin
			if (rows_q[i].op == OP_A15) begin
				a15_edges += rows_q[i].data;
			end
		end
		cycle_limit = rows_q.size() * 8 + a15_edges * 2 + reset_cycles;   // Two cycles per edge

		repeat (reset_cycles) @(posedge clk_sys);
		#1 rst_n = 1'b1;

		foreach (rows_q[i]) begin
			apply_row(rows_q[i]);
		end

		if (fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
common/cart_pkg.sv
common/mapper_state_pkg.sv
hw/mappers/rocket.sv
hw/mappers/mbc1.sv
hw/cart_config.sv
hw/cart_top.sv
verif/cart_properties.sv
verif/cart_tb.sv
